/* source/hdr_cfg.svh */
// Widths and protocol constants for the header parser datapath
// The data word is fixed at 64 bits with one strobe bit per byte
// Only the first VLAN tag of a stacked set is ever reported
`ifndef HDR_CFG_SVH
`define HDR_CFG_SVH

// Stream word and sideband widths
`define HDR_DATA_W 64
`define HDR_STRB_W 8
`define HDR_LEN_W 16
`define HDR_SPT_W 8

// EtherTypes
`define TYPE_IP 16'h0800
`define TYPE_VLAN 16'h8100
`define TYPE_VLAN_QINQ 16'h88a8
`define NO_VLAN 16'hffff

// IP protocol numbers
`define PROTO_ICMP 8'h01
`define PROTO_TCP 8'h06
`define PROTO_UDP 8'h11
`define PROTO_SCTP 8'h84

// Filler bits for the last aligned word
`define HDR_PAD16 16'h900d
`define HDR_PAD48 48'hcafe_beef_f00d

`endif

/* source/hdr_pkg.sv */
// Shared types of the header parser
// The transport word is always 32 bits, in network byte order

package hdr_pkg;

   // First 32 bits of the transport header, two views of one word
   typedef union packed {
      struct packed {
         logic [15:0] src;
         logic [15:0] dst;
      } ports;
      struct packed {
         logic [7:0]  icmp_type;
         logic [7:0]  icmp_code;
         logic [15:0] csum;
      } icmp;
   } tp_word_u;

   typedef enum logic [1:0] {RD_FIRST, RD_REST, RD_WAIT} rd_state_e;

   typedef enum logic [3:0] {
      L2_FIRST, L2_SECOND, L2_VLAN,
      L2_SFT16_1ST, L2_SFT16, L2_TAIL16,
      L2_SFT48_1ST, L2_SFT48, L2_TAIL48
   } l2_state_e;

   typedef enum logic [2:0] {IP_IDLE, IP_2ND, IP_3RD, IP_MORE, IP_HOLD} ip_state_e;

endpackage

/* source/word_reader.sv */
// Pulls packets from a first-word-fall-through FIFO, one per pass
// Input words are little endian, outputs are in network byte order
// Needs at least two words per packet, one idle cycle follows each packet
`timescale 1ns/1ps
`include "hdr_cfg.svh"

module word_reader import hdr_pkg::*; (
   input  logic                   asclk,
   input  logic                   aresetn,
   input  logic [`HDR_DATA_W-1:0] tx_data,
   input  logic [`HDR_STRB_W-1:0] tx_strb,
   input  logic                   tx_valid,
   input  logic                   tx_last,
   input  logic [`HDR_LEN_W-1:0]  tx_len_data,
   input  logic [`HDR_SPT_W-1:0]  tx_spt_data,
   input  logic                   fifo_empty,
   output logic                   fifo_rd_en,
   output logic                   tx_user_rd_en,
   output logic [`HDR_DATA_W-1:0] be_data,
   output logic [`HDR_STRB_W-1:0] be_strb,
   output logic                   word_valid,
   output logic                   word_last,
   output logic                   vlan_hi,
   output logic                   vlan_lo,
   output logic [`HDR_LEN_W-1:0]  pkt_len_in,
   output logic [`HDR_SPT_W-1:0]  src_port_in
);

   rd_state_e state, state_nxt;
   logic [`HDR_DATA_W-1:0] swap_data;
   logic [`HDR_STRB_W-1:0] swap_strb;
   logic valid_nxt, last_nxt;

   // Byte reversal of data and strobe
   always_comb begin
      for (int i = 0; i < `HDR_STRB_W; i++) begin
         swap_data[8*(`HDR_STRB_W-1-i) +: 8] = tx_data[8*i +: 8];
         swap_strb[`HDR_STRB_W-1-i] = tx_strb[i];
      end
   end

   always_comb begin
      state_nxt = state;
      fifo_rd_en = 1'b0;
      tx_user_rd_en = 1'b0;
      valid_nxt = 1'b0;
      last_nxt = 1'b0;
      case (state)
         RD_FIRST: begin
            if (!fifo_empty) begin
               fifo_rd_en = 1'b1;
               tx_user_rd_en = 1'b1;
               valid_nxt = tx_valid;
               state_nxt = RD_REST;
            end
         end
         RD_REST: begin
            if (!fifo_empty) begin
               fifo_rd_en = 1'b1;
               valid_nxt = tx_valid;
               last_nxt = tx_last;
               if (tx_last) begin
                  state_nxt = RD_WAIT;
               end
            end
         end
         // Gap so the aligner can flush its tail word
         RD_WAIT: state_nxt = RD_FIRST;
         default: state_nxt = RD_FIRST;
      endcase
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         state <= RD_FIRST;
         word_valid <= 1'b0;
         word_last <= 1'b0;
      end else begin
         state <= state_nxt;
         word_valid <= valid_nxt;
         word_last <= last_nxt;
      end
   end

   // Payload and sideband, only meaningful with word_valid
   always_ff @(posedge asclk) begin
      be_data <= swap_data;
      be_strb <= swap_strb;
      pkt_len_in <= tx_len_data;
      src_port_in <= tx_spt_data;
      // EtherType lanes precomputed for the aligner
      vlan_hi <= (swap_data[63:48] == `TYPE_VLAN) || (swap_data[63:48] == `TYPE_VLAN_QINQ);
      vlan_lo <= (swap_data[31:16] == `TYPE_VLAN) || (swap_data[31:16] == `TYPE_VLAN_QINQ);
   end

   // FIFO is never popped when empty
   assert property (@(posedge asclk) disable iff (!aresetn) fifo_empty |-> !fifo_rd_en);

endmodule

/* source/l2_aligner.sv */
// Extracts the L2 header and re-aligns the rest so L3 starts at bit 63
// Stacked VLAN tags are skipped, only the first tag is reported
// Every EtherType other than IPv4 finishes as plain L2 on dl_done
`timescale 1ns/1ps
`include "hdr_cfg.svh"

module l2_aligner import hdr_pkg::*; (
   input  logic                   asclk,
   input  logic                   aresetn,
   input  logic [`HDR_DATA_W-1:0] be_data,
   input  logic [`HDR_STRB_W-1:0] be_strb,
   input  logic                   word_valid,
   input  logic                   word_last,
   input  logic                   vlan_hi,
   input  logic                   vlan_lo,
   input  logic [`HDR_LEN_W-1:0]  pkt_len_in,
   input  logic [`HDR_SPT_W-1:0]  src_port_in,
   output logic                   dl_start,
   output logic                   dl_done,
   output logic [`HDR_LEN_W-1:0]  pkt_len,
   output logic [`HDR_SPT_W-1:0]  src_port,
   output logic [47:0]            dl_dst,
   output logic [47:0]            dl_src,
   output logic [15:0]            dl_ethtype,
   output logic [15:0]            dl_vlantag,
   output logic [`HDR_DATA_W-1:0] al_data,
   output logic                   al_valid,
   output logic                   ip_start
);

   l2_state_e state, state_nxt;
   logic [15:0] buf16, buf16_nxt;
   logic [47:0] buf48, buf48_nxt;
   logic [`HDR_DATA_W-1:0] al_data_nxt;
   logic al_valid_nxt, dl_start_nxt, dl_done_nxt, ip_start_nxt;
   logic [`HDR_LEN_W-1:0] pkt_len_nxt;
   logic [`HDR_SPT_W-1:0] src_port_nxt;
   logic [47:0] dl_dst_nxt, dl_src_nxt;
   logic [15:0] dl_ethtype_nxt, dl_vlantag_nxt;
   logic shift_first;

   assign shift_first = (state == L2_SFT16_1ST) || (state == L2_SFT48_1ST);

   always_comb begin
      state_nxt = state;
      buf16_nxt = buf16;
      buf48_nxt = buf48;
      al_data_nxt = al_data;
      al_valid_nxt = 1'b0;
      dl_start_nxt = 1'b0;
      dl_done_nxt = 1'b0;
      ip_start_nxt = 1'b0;
      pkt_len_nxt = pkt_len;
      src_port_nxt = src_port;
      dl_dst_nxt = dl_dst;
      dl_src_nxt = dl_src;
      dl_ethtype_nxt = dl_ethtype;
      dl_vlantag_nxt = dl_vlantag;
      case (state)
         L2_FIRST: begin
            if (word_valid) begin
               pkt_len_nxt = pkt_len_in;
               src_port_nxt = src_port_in;
               dl_dst_nxt = be_data[63:16];
               dl_src_nxt = {be_data[15:0], dl_src[31:0]};
               dl_start_nxt = 1'b1;
               state_nxt = L2_SECOND;
            end
         end
         L2_SECOND: begin
            if (word_valid) begin
               dl_src_nxt = {dl_src[47:32], be_data[63:32]};
               dl_ethtype_nxt = be_data[31:16];
               if (vlan_lo) begin
                  dl_vlantag_nxt = be_data[15:0];
                  state_nxt = L2_VLAN;
               end else begin
                  dl_vlantag_nxt = `NO_VLAN;
                  buf16_nxt = be_data[15:0];
                  state_nxt = L2_SFT16_1ST;
               end
            end
         end
         // Inner tags, stays here while both lanes hold a VLAN type
         L2_VLAN: begin
            if (word_valid) begin
               if (!vlan_hi) begin
                  dl_ethtype_nxt = be_data[63:48];
                  buf48_nxt = be_data[47:0];
                  state_nxt = L2_SFT48_1ST;
               end else if (!vlan_lo) begin
                  dl_ethtype_nxt = be_data[31:16];
                  buf16_nxt = be_data[15:0];
                  state_nxt = L2_SFT16_1ST;
               end
            end
         end
         L2_SFT16_1ST, L2_SFT16: begin
            if (word_valid) begin
               al_data_nxt = {buf16, be_data[63:16]};
               buf16_nxt = be_data[15:0];
               al_valid_nxt = 1'b1;
               state_nxt = L2_SFT16;
               if (word_last) begin
                  state_nxt = (|be_strb[1:0]) ? L2_TAIL16 : L2_FIRST;
               end
            end
         end
         L2_TAIL16: begin
            al_data_nxt = {buf16, `HDR_PAD48};
            al_valid_nxt = 1'b1;
            state_nxt = L2_FIRST;
         end
         L2_SFT48_1ST, L2_SFT48: begin
            if (word_valid) begin
               al_data_nxt = {buf48, be_data[63:48]};
               buf48_nxt = be_data[47:0];
               al_valid_nxt = 1'b1;
               state_nxt = L2_SFT48;
               if (word_last) begin
                  state_nxt = (|be_strb[5:0]) ? L2_TAIL48 : L2_FIRST;
               end
            end
         end
         L2_TAIL48: begin
            al_data_nxt = {buf48, `HDR_PAD16};
            al_valid_nxt = 1'b1;
            state_nxt = L2_FIRST;
         end
         default: state_nxt = L2_FIRST;
      endcase
      // EtherType dispatch on the first aligned word
      if (shift_first && word_valid) begin
         ip_start_nxt = (dl_ethtype == `TYPE_IP);
         dl_done_nxt = (dl_ethtype != `TYPE_IP);
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         state <= L2_FIRST;
         al_valid <= 1'b0;
         dl_start <= 1'b0;
         dl_done <= 1'b0;
         ip_start <= 1'b0;
      end else begin
         state <= state_nxt;
         al_valid <= al_valid_nxt;
         dl_start <= dl_start_nxt;
         dl_done <= dl_done_nxt;
         ip_start <= ip_start_nxt;
      end
   end

   always_ff @(posedge asclk) begin
      buf16 <= buf16_nxt;
      buf48 <= buf48_nxt;
      al_data <= al_data_nxt;
      pkt_len <= pkt_len_nxt;
      src_port <= src_port_nxt;
      dl_dst <= dl_dst_nxt;
      dl_src <= dl_src_nxt;
      dl_ethtype <= dl_ethtype_nxt;
      dl_vlantag <= dl_vlantag_nxt;
   end

   // One dispatch per packet, always on an aligned word
   assert property (@(posedge asclk) disable iff (!aresetn) !(ip_start && dl_done));
   assert property (@(posedge asclk) disable iff (!aresetn) (ip_start || dl_done) |-> al_valid);

endmodule

/* source/ip_tp_parser.sv */
// IPv4 and transport field extraction over the aligned word stream
// Fragments report zero ports, an IHL of 4 clears all IP fields
// Holds its result until compose_done, a start seen while holding is lost
`timescale 1ns/1ps
`include "hdr_cfg.svh"

module ip_tp_parser import hdr_pkg::*; (
   input  logic                   asclk,
   input  logic                   aresetn,
   input  logic [`HDR_DATA_W-1:0] al_data,
   input  logic                   al_valid,
   input  logic                   ip_start,
   input  logic                   compose_done,
   output logic                   ip_tp_done,
   output logic [5:0]             ip_tos,
   output logic [7:0]             ip_proto,
   output logic [31:0]            ip_src,
   output logic [31:0]            ip_dst,
   output logic [15:0]            tp_src,
   output logic [15:0]            tp_dst
);

   ip_state_e state, state_nxt;
   // Remaining header in 32-bit half-words
   logic [4:0] hlen, hlen_nxt;
   logic frag, frag_nxt;
   logic ip_tp_done_nxt;
   logic [5:0] ip_tos_nxt;
   logic [7:0] ip_proto_nxt;
   logic [31:0] ip_src_nxt, ip_dst_nxt;
   logic [15:0] tp_src_nxt, tp_dst_nxt;
   logic [15:0] tp_src_dec, tp_dst_dec;
   logic tp_in_hi;
   tp_word_u tp_word;

   // Upper half only when the count ran out on the previous word
   assign tp_in_hi = (state == IP_MORE) && (hlen == 5'd0);
   assign tp_word = tp_in_hi ? al_data[63:32] : al_data[31:0];

   always_comb begin
      case (ip_proto)
         `PROTO_ICMP: begin
            tp_src_dec = {8'h00, tp_word.icmp.icmp_type};
            tp_dst_dec = {8'h00, tp_word.icmp.icmp_code};
         end
         `PROTO_TCP, `PROTO_UDP, `PROTO_SCTP: begin
            tp_src_dec = tp_word.ports.src;
            tp_dst_dec = tp_word.ports.dst;
         end
         default: begin
            tp_src_dec = 16'h0000;
            tp_dst_dec = 16'h0000;
         end
      endcase
   end

   always_comb begin
      state_nxt = state;
      hlen_nxt = hlen;
      frag_nxt = frag;
      ip_tp_done_nxt = 1'b0;
      ip_tos_nxt = ip_tos;
      ip_proto_nxt = ip_proto;
      ip_src_nxt = ip_src;
      ip_dst_nxt = ip_dst;
      tp_src_nxt = tp_src;
      tp_dst_nxt = tp_dst;
      case (state)
         IP_IDLE: begin
            if (ip_start) begin
               hlen_nxt = {1'b0, al_data[59:56]} - 5'd2;
               ip_tos_nxt = al_data[55:50];
               // MF flag or a non-zero fragment offset
               frag_nxt = al_data[13] || (|al_data[12:0]);
               state_nxt = IP_2ND;
            end
         end
         IP_2ND: begin
            if (al_valid) begin
               hlen_nxt = hlen - 5'd2;
               ip_proto_nxt = al_data[55:48];
               ip_src_nxt = al_data[31:0];
               state_nxt = IP_3RD;
            end
         end
         IP_3RD: begin
            if (al_valid) begin
               ip_dst_nxt = al_data[63:32];
               if (frag || hlen == 5'd0) begin
                  ip_tp_done_nxt = 1'b1;
                  tp_src_nxt = 16'h0000;
                  tp_dst_nxt = 16'h0000;
                  state_nxt = IP_HOLD;
                  if (!frag) begin
                     // Header shorter than 20 bytes
                     ip_tos_nxt = 6'd0;
                     ip_proto_nxt = 8'h00;
                     ip_src_nxt = 32'h0;
                     ip_dst_nxt = 32'h0;
                  end
               end else if (hlen == 5'd1) begin
                  ip_tp_done_nxt = 1'b1;
                  tp_src_nxt = tp_src_dec;
                  tp_dst_nxt = tp_dst_dec;
                  state_nxt = IP_HOLD;
               end else begin
                  hlen_nxt = hlen - 5'd2;
                  state_nxt = IP_MORE;
               end
            end
         end
         IP_MORE: begin
            if (al_valid) begin
               if (hlen <= 5'd1) begin
                  ip_tp_done_nxt = 1'b1;
                  tp_src_nxt = tp_src_dec;
                  tp_dst_nxt = tp_dst_dec;
                  state_nxt = IP_HOLD;
               end else begin
                  hlen_nxt = hlen - 5'd2;
               end
            end
         end
         IP_HOLD: begin
            if (compose_done) begin
               state_nxt = IP_IDLE;
            end
         end
         default: state_nxt = IP_IDLE;
      endcase
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         state <= IP_IDLE;
         hlen <= 5'd0;
         frag <= 1'b0;
         ip_tp_done <= 1'b0;
      end else begin
         state <= state_nxt;
         hlen <= hlen_nxt;
         frag <= frag_nxt;
         ip_tp_done <= ip_tp_done_nxt;
      end
   end

   always_ff @(posedge asclk) begin
      ip_tos <= ip_tos_nxt;
      ip_proto <= ip_proto_nxt;
      ip_src <= ip_src_nxt;
      ip_dst <= ip_dst_nxt;
      tp_src <= tp_src_nxt;
      tp_dst <= tp_dst_nxt;
   end

   // No second result while the first is still held
   assert property (@(posedge asclk) disable iff (!aresetn)
      (state == IP_HOLD && $past(state == IP_HOLD)) |-> !ip_tp_done);

endmodule

/* source/header_parser.sv */
// Ethernet header parser top with L2 and IP parse counters
// Counters wrap at their maximum and are cleared only by reset
`timescale 1ns/1ps
`include "hdr_cfg.svh"

module header_parser (
   input  logic                   asclk,
   input  logic                   aresetn,
   input  logic [`HDR_DATA_W-1:0] tx_data,
   input  logic [`HDR_STRB_W-1:0] tx_strb,
   input  logic                   tx_valid,
   input  logic                   tx_last,
   input  logic [`HDR_LEN_W-1:0]  tx_len_data,
   input  logic [`HDR_SPT_W-1:0]  tx_spt_data,
   input  logic                   fifo_empty,
   output logic                   fifo_rd_en,
   output logic                   tx_user_rd_en,
   output logic                   dl_start,
   output logic                   dl_done,
   output logic [`HDR_LEN_W-1:0]  pkt_len,
   output logic [`HDR_SPT_W-1:0]  src_port,
   output logic [47:0]            dl_dst,
   output logic [47:0]            dl_src,
   output logic [15:0]            dl_ethtype,
   output logic [15:0]            dl_vlantag,
   output logic                   ip_tp_done,
   output logic [5:0]             ip_tos,
   output logic [7:0]             ip_proto,
   output logic [31:0]            ip_src,
   output logic [31:0]            ip_dst,
   output logic [15:0]            tp_src,
   output logic [15:0]            tp_dst,
   input  logic                   compose_done,
   output logic [31:0]            dl_parse_cnt,
   output logic [31:0]            ip_tp_parse_cnt
);

   // Reader to aligner
   logic [`HDR_DATA_W-1:0] be_data;
   logic [`HDR_STRB_W-1:0] be_strb;
   logic word_valid, word_last;
   logic vlan_hi, vlan_lo;
   logic [`HDR_LEN_W-1:0] pkt_len_in;
   logic [`HDR_SPT_W-1:0] src_port_in;

   // Aligner to IP parser
   logic [`HDR_DATA_W-1:0] al_data;
   logic al_valid, ip_start;

   word_reader word_reader_i (.*);

   l2_aligner l2_aligner_i (.*);

   ip_tp_parser ip_tp_parser_i (.*);

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         dl_parse_cnt <= 32'd0;
         ip_tp_parse_cnt <= 32'd0;
      end else begin
         if (dl_done) begin
            dl_parse_cnt <= dl_parse_cnt + 32'd1;
         end
         if (ip_tp_done) begin
            ip_tp_parse_cnt <= ip_tp_parse_cnt + 32'd1;
         end
      end
   end

endmodule

/* tb/tb_header_parser.sv */
// Testbench for the header parser, driven from tb/packets_golden.txt
// Golden words are in network byte order and are byte-swapped onto the stream
// Run from the project root so that the golden file path resolves
`timescale 1ns/1ps
`include "hdr_cfg.svh"

module tb_header_parser;

   logic asclk, aresetn;
   logic [`HDR_DATA_W-1:0] tx_data;
   logic [`HDR_STRB_W-1:0] tx_strb;
   logic tx_valid, tx_last, fifo_empty, compose_done;
   logic [`HDR_LEN_W-1:0] tx_len_data;
   logic [`HDR_SPT_W-1:0] tx_spt_data;
   logic fifo_rd_en, tx_user_rd_en, dl_start, dl_done, ip_tp_done;
   logic [`HDR_LEN_W-1:0] pkt_len;
   logic [`HDR_SPT_W-1:0] src_port;
   logic [47:0] dl_dst, dl_src;
   logic [15:0] dl_ethtype, dl_vlantag, tp_src, tp_dst;
   logic [5:0] ip_tos;
   logic [7:0] ip_proto;
   logic [31:0] ip_src, ip_dst, dl_parse_cnt, ip_tp_parse_cnt;

   logic [63:0] gold [0:511];
   logic [63:0] fifo_data [0:255];
   logic [7:0] fifo_strb [0:255];
   logic fifo_last [0:255];
   int wr_ptr, rd_ptr, done_cnt, errs, cycles;
   int rd_pulses, start_pulses, rd_cycle, start_cycle;
   int limit = 100000;
   int seed = 32'h7bdd_ffbf;

   header_parser header_parser_i (.*);

   always #20 asclk = ~asclk;

   // Little-endian stream word from a network-order word
   function automatic logic [63:0] byte_swap(input logic [63:0] w);
      logic [63:0] r;
      for (int i = 0; i < 8; i++) begin
         r[8*(7-i) +: 8] = w[8*i +: 8];
      end
      return r;
   endfunction

   function automatic string name_of(input logic [63:0] id);
      case (id)
         64'd1: return "ipv4_udp";
         64'd2: return "vlan_tcp_ihl6";
         64'd3: return "qinq_icmp";
         64'd4: return "frag_udp";
         64'd5: return "ipv4_unknown_proto";
         64'd6: return "non_ip";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_value(input string test, input string field,
                              input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s %s expected %h actual %h", test, field, exp, act);
         errs++;
      end
   endtask

   // FIFO model, first-word-fall-through, pops on fifo_rd_en
   always @(posedge asclk) begin
      int nxt;
      int rnd;
      nxt = rd_ptr;
      if (fifo_rd_en) begin
         nxt = nxt + 1;
      end
      rnd = $random(seed);
      rd_ptr <= nxt;
      fifo_empty <= (nxt >= wr_ptr) || (rnd[1:0] == 2'b00);
      tx_data <= byte_swap(fifo_data[nxt]);
      tx_strb <= fifo_strb[nxt];
      tx_last <= fifo_last[nxt];
   end

   // Pulse counts and the cycle of the latest read and start strobes
   always @(posedge asclk) begin
      if (aresetn && (dl_done || ip_tp_done)) begin
         done_cnt <= done_cnt + 1;
      end
      if (aresetn && tx_user_rd_en) begin
         rd_pulses <= rd_pulses + 1;
         rd_cycle <= cycles;
      end
      if (aresetn && dl_start) begin
         start_pulses <= start_pulses + 1;
         start_cycle <= cycles;
      end
   end

   always @(posedge asclk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout after %0d cycles, a done pulse never arrived", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial begin
      int p, n, e, total, ntests, exp_dl, exp_ip, passes, fails, errs_before, cnt_before;
      int rd_before, start_before;
      string name;
      asclk = 1'b0;
      aresetn = 1'b0;
      tx_data = '0;
      tx_strb = '0;
      tx_valid = 1'b1;
      tx_last = 1'b0;
      tx_len_data = '0;
      tx_spt_data = '0;
      fifo_empty = 1'b1;
      compose_done = 1'b0;
      wr_ptr = 0;
      rd_ptr = 0;
      done_cnt = 0;
      rd_pulses = 0;
      start_pulses = 0;
      rd_cycle = 0;
      start_cycle = 0;
      errs = 0;
      cycles = 0;
      exp_dl = 0;
      exp_ip = 0;
      passes = 0;
      fails = 0;
      $readmemh("tb/packets_golden.txt", gold);

      // Cycle budget from the golden word count
      p = 0;
      total = 0;
      ntests = 0;
      while (gold[p] != 64'hffff) begin
         n = int'(gold[p+3]);
         total = total + n;
         ntests++;
         p = p + 4 + 2*n + 11;
      end
      limit = total*4 + ntests*40 + 200;

      repeat (5) @(posedge asclk);
      aresetn <= 1'b1;

      p = 0;
      while (gold[p] != 64'hffff) begin
         name = name_of(gold[p]);
         n = int'(gold[p+3]);
         e = p + 4 + 2*n;
         errs_before = errs;
         cnt_before = done_cnt;
         rd_before = rd_pulses;
         start_before = start_pulses;
         @(posedge asclk);
         tx_spt_data <= gold[p+1][7:0];
         tx_len_data <= gold[p+2][15:0];
         for (int i = 0; i < n; i++) begin
            fifo_data[wr_ptr+i] <= gold[p+4+2*i];
            fifo_strb[wr_ptr+i] <= gold[p+5+2*i][7:0];
            fifo_last[wr_ptr+i] <= (i == n-1);
         end
         wr_ptr <= wr_ptr + n;

         do @(negedge asclk); while (!(dl_done || ip_tp_done));
         check_value(name, "done_kind", gold[e+10], {63'd0, ip_tp_done});
         check_value(name, "pkt_len", gold[p+2], 64'(pkt_len));
         check_value(name, "src_port", gold[p+1], 64'(src_port));
         check_value(name, "dl_dst", gold[e], 64'(dl_dst));
         check_value(name, "dl_src", gold[e+1], 64'(dl_src));
         check_value(name, "dl_ethtype", gold[e+2], 64'(dl_ethtype));
         check_value(name, "dl_vlantag", gold[e+3], 64'(dl_vlantag));
         if (gold[e+10] == 64'd1) begin
            exp_ip++;
            check_value(name, "ip_tos", gold[e+4], 64'(ip_tos));
            check_value(name, "ip_proto", gold[e+5], 64'(ip_proto));
            check_value(name, "ip_src", gold[e+6], 64'(ip_src));
            check_value(name, "ip_dst", gold[e+7], 64'(ip_dst));
            check_value(name, "tp_src", gold[e+8], 64'(tp_src));
            check_value(name, "tp_dst", gold[e+9], 64'(tp_dst));
         end else begin
            exp_dl++;
         end

         // Release the IP parser, then drain the packet
         @(posedge asclk);
         compose_done <= 1'b1;
         @(posedge asclk);
         compose_done <= 1'b0;
         while (rd_ptr != wr_ptr) @(negedge asclk);
         repeat (8) @(negedge asclk);
         check_value(name, "done_pulses", 64'd1, 64'(done_cnt - cnt_before));
         check_value(name, "user_rd_pulses", 64'd1, 64'(rd_pulses - rd_before));
         check_value(name, "dl_start_pulses", 64'd1, 64'(start_pulses - start_before));
         // dl_start follows the first read by two cycles
         check_value(name, "dl_start_delay", 64'd2, 64'(start_cycle - rd_cycle));

         if (errs == errs_before) begin
            passes++;
            $display("%s: ok", name);
         end else begin
            fails++;
            $display("%s: failed", name);
         end
         p = e + 11;
      end

      errs_before = errs;
      check_value("parse_counters", "dl_parse_cnt", 64'(exp_dl), 64'(dl_parse_cnt));
      check_value("parse_counters", "ip_tp_parse_cnt", 64'(exp_ip), 64'(ip_tp_parse_cnt));
      if (errs == errs_before) begin
         passes++;
         $display("parse_counters: ok");
      end else begin
         fails++;
         $display("parse_counters: failed");
      end

      $display("%0d tests passed, %0d tests failed", passes, fails);
      if (fails == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* tb/packets_golden.txt */
// Record: id port len nwords, then nwords pairs of data (network order) and tx_strb,
// then dst src ethtype vlan tos proto ip_src ip_dst tp_src tp_dst done (1 = IP); ffff ends
1 03 2c 6
0a0b0c0d0e0f1020 ff 3040506008004528 ff
002e123400004011 ff abcdc0a80001c0a8 ff
00021f9000350012 ff 0000dead00000000 0f
0a0b0c0d0e0f 102030405060 0800 ffff 0a 11 c0a80001 c0a80002 1f90 0035 1
2 05 34 7
0011223344556677 ff 8899aabb81000064 ff
0800460000345678 ff 4000400611110a00 ff
00010a0000020101 ff 01010050c3500000 ff
0001000200000000 0f
001122334455 66778899aabb 0800 0064 00 06 0a000001 0a000002 0050 c350 1
3 07 34 7
a1a2a3a4a5a6b1b2 ff b3b4b5b688a80c01 ff
81000c02080045b8 ff 001c000100004001 ff
ffff010203040506 ff 07080800f7ff0000 ff
0000000000000000 0f
a1a2a3a4a5a6 b1b2b3b4b5b6 0800 0c01 2e 01 01020304 05060708 0008 0000 1
4 01 2a 6
0200000000010200 ff 0000000208004500 ff
0030abcd20004011 ff 00000a0a0a0a0b0b ff
0b0b111122220008 ff 0000000000000000 03
020000000001 020000000002 0800 ffff 00 11 0a0a0a0a 0b0b0b0b 0000 0000 1
5 02 2a 6
0c0c0c0c0c0c0d0d ff 0d0d0d0d08004504 ff
002800000000402f ff 0000c0000201c000 ff
0202aaaabbbb0000 ff 1234000000000000 03
0c0c0c0c0c0c 0d0d0d0d0d0d 0800 ffff 01 2f c0000201 c0000202 0000 0000 1
6 0a 1a 4
0180c200000e001b ff 21aabbcc88cc0203 ff
0405060708090a0b ff 0c0d000000000000 03
0180c200000e 001b21aabbcc 88cc ffff 00 00 00000000 00000000 0000 0000 0
ffff

/* flist.f */
+incdir+source
source/hdr_pkg.sv
source/word_reader.sv
source/l2_aligner.sv
source/ip_tp_parser.sv
source/header_parser.sv
tb/tb_header_parser.sv

/* run.sh */
#!/bin/sh
# Build and run the header parser testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_header_parser -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -F "TEST PASS" > /dev/null && exit 0 || exit 1
